//--- filelist.f
hdl/CorePkg.sv
hdl/RegFile.sv
hdl/IntALU.sv
hdl/IssueQueue.sv
hdl/Rename.sv
hdl/ROB.sv
hdl/Core.sv
test/CoreTb.sv

//--- hdl/Core.sv
module Core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instrValid,
    input  CorePkg::DispatchInstr instr,
    output logic                 stall,
    output CorePkg::CommitInfo   commit
);
    import CorePkg::*;

    RenamedUOp renUOp;
    RenamedUOp issueUOp;
    RobAlloc robAlloc;
    ResultBus result;
    RobIdx allocIdx;
    PhysTag freeTag;
    PhysTag readTagA;
    PhysTag readTagB;
    Word readA;
    Word readB;
    logic enqValid;
    logic iqFull;
    logic robFull;
    logic freeValid;
    logic issueValid;

    Rename rn (
        .clk(clk),
        .rst(rst),
        .instrValid(instrValid),
        .instr(instr),
        .iqFull(iqFull),
        .robFull(robFull),
        .allocIdx(allocIdx),
        .result(result),
        .freeValid(freeValid),
        .freeTag(freeTag),
        .stall(stall),
        .enqValid(enqValid),
        .uop(renUOp),
        .robAlloc(robAlloc)
    );

    IssueQueue iq (
        .clk(clk),
        .rst(rst),
        .enqValid(enqValid),
        .uop(renUOp),
        .result(result),
        .full(iqFull),
        .issueValid(issueValid),
        .issueUOp(issueUOp)
    );

    RegFile rf (
        .clk(clk),
        .rst(rst),
        .readTagA(readTagA),
        .readTagB(readTagB),
        .readA(readA),
        .readB(readB),
        .result(result)
    );

    IntALU ialu (
        .clk(clk),
        .rst(rst),
        .issueValid(issueValid),
        .issueUOp(issueUOp),
        .readTagA(readTagA),
        .readTagB(readTagB),
        .readA(readA),
        .readB(readB),
        .result(result)
    );

    ROB rob (
        .clk(clk),
        .rst(rst),
        .allocValid(enqValid), // Same strobe as the queue write.
        .robAlloc(robAlloc),
        .allocIdx(allocIdx),
        .full(robFull),
        .result(result),
        .commit(commit),
        .freeValid(freeValid),
        .freeTag(freeTag)
    );

endmodule

//--- hdl/CorePkg.sv
package CorePkg;

    localparam int XLEN = 32;
    localparam int NUM_ARCH_REGS = 8;
    localparam int NUM_PHYS_REGS = 16;
    localparam int ROB_SIZE = 8;
    localparam int IQ_SIZE = 4;
    localparam int IMM_BITS = 12;

    typedef logic [XLEN-1:0] Word;
    typedef logic [$clog2(NUM_ARCH_REGS)-1:0] ArchReg; // Register 0 always reads zero.
    typedef logic [$clog2(NUM_PHYS_REGS)-1:0] PhysTag;
    typedef logic [$clog2(ROB_SIZE)-1:0] RobIdx;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT, // Signed compare.
        SLL,
        SRL
    } AluOp;

    // A decoded instruction as it arrives from the front end.
    typedef struct packed {
        AluOp op;
        ArchReg rd;
        ArchReg rs1;
        ArchReg rs2;
        logic useImm; // Sign-extended imm replaces rs2.
        logic [IMM_BITS-1:0] imm;
    } DispatchInstr;

    typedef struct packed {
        AluOp op;
        logic hasDst;
        PhysTag tagDst;
        PhysTag tagA;
        logic readyA;
        PhysTag tagB;
        logic readyB;
        logic useImm;
        logic [IMM_BITS-1:0] imm;
        RobIdx robIdx;
    } RenamedUOp;

    typedef struct packed {
        ArchReg rd;
        logic hasDst;
        PhysTag tagOld; // Mapping that is released when this entry commits.
    } RobAlloc;

    typedef struct packed {
        logic valid;
        logic hasDst;
        PhysTag tagDst;
        RobIdx robIdx;
        Word result;
    } ResultBus;

    typedef struct packed {
        logic valid;
        ArchReg rd;
        Word value;
    } CommitInfo;

endpackage

//--- hdl/IntALU.sv
module IntALU (
    input  logic               clk,
    input  logic               rst,
    input  logic               issueValid,
    input  CorePkg::RenamedUOp issueUOp,
    output CorePkg::PhysTag    readTagA,
    output CorePkg::PhysTag    readTagB,
    input  CorePkg::Word       readA,
    input  CorePkg::Word       readB,
    output CorePkg::ResultBus  result
);
    import CorePkg::*;

    Word opA;
    Word opB;
    Word value;

    assign readTagA = issueUOp.tagA;
    assign readTagB = issueUOp.tagB;
    assign opA = readA;
    assign opB = issueUOp.useImm ?
        {{(XLEN - IMM_BITS){issueUOp.imm[IMM_BITS-1]}}, issueUOp.imm} : readB;

    always_comb begin
        case (issueUOp.op)
            ADD: value = opA + opB;
            SUB: value = opA - opB;
            AND: value = opA & opB;
            OR:  value = opA | opB;
            XOR: value = opA ^ opB;
            SLT: value = Word'($signed(opA) < $signed(opB));
            SLL: value = opA << opB[4:0]; // Shift amount is the low five bits.
            SRL: value = opA >> opB[4:0];
        endcase
    end

    always_ff @(posedge clk) begin
        result.hasDst <= issueUOp.hasDst;
        result.tagDst <= issueUOp.tagDst;
        result.robIdx <= issueUOp.robIdx;
        result.result <= value;
        if (rst)
            result.valid <= 1'b0;
        else
            result.valid <= issueValid;
    end

endmodule

//--- hdl/IssueQueue.sv
module IssueQueue (
    input  logic               clk,
    input  logic               rst,
    input  logic               enqValid,
    input  CorePkg::RenamedUOp uop,
    input  CorePkg::ResultBus  result,
    output logic               full,
    output logic               issueValid,
    output CorePkg::RenamedUOp issueUOp
);
    import CorePkg::*;

    typedef logic [$clog2(IQ_SIZE)-1:0] Slot;

    RenamedUOp entries [IQ_SIZE]; // Index 0 is the oldest.
    RenamedUOp woken [IQ_SIZE];
    RenamedUOp shifted [IQ_SIZE];
    logic [$clog2(IQ_SIZE+1)-1:0] count;
    Slot pick;
    Slot enqPos;
    logic found;
    logic resWrites;

    assign full = count == IQ_SIZE;
    assign resWrites = result.valid && result.hasDst;

    // New entries land behind the survivors after compaction.
    assign enqPos = Slot'(count - found);

    always_comb begin
        found = 1'b0;
        pick = '0;
        for (int i = IQ_SIZE - 1; i >= 0; i--) begin
            woken[i] = entries[i];
            if (resWrites && result.tagDst == entries[i].tagA)
                woken[i].readyA = 1'b1;
            if (resWrites && result.tagDst == entries[i].tagB)
                woken[i].readyB = 1'b1;

            // Scanning downwards leaves the oldest ready entry selected.
            if (i < count && woken[i].readyA && woken[i].readyB) begin
                found = 1'b1;
                pick = Slot'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < IQ_SIZE - 1; i++) begin
            shifted[i] = (found && i >= pick) ? woken[i+1] : woken[i];
        end
        shifted[IQ_SIZE-1] = woken[IQ_SIZE-1];
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            entries[i] <= shifted[i];
        end
        if (enqValid)
            entries[enqPos] <= uop;
        if (found)
            issueUOp <= woken[pick];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            issueValid <= 1'b0;
        end else begin
            count <= count + enqValid - found;
            issueValid <= found;
        end
    end

endmodule

//--- hdl/ROB.sv
module ROB (
    input  logic              clk,
    input  logic              rst,
    input  logic              allocValid,
    input  CorePkg::RobAlloc  robAlloc,
    output CorePkg::RobIdx    allocIdx,
    output logic              full,
    input  CorePkg::ResultBus result,
    output CorePkg::CommitInfo commit,
    output logic              freeValid,
    output CorePkg::PhysTag   freeTag
);
    import CorePkg::*;

    RobAlloc info [ROB_SIZE];
    Word value [ROB_SIZE];
    logic [ROB_SIZE-1:0] done;
    RobIdx head;
    RobIdx tail;
    logic [$clog2(ROB_SIZE+1)-1:0] count;
    logic doCommit;

    assign allocIdx = tail;
    assign full = count == ROB_SIZE;
    assign doCommit = count != '0 && done[head];

    always_ff @(posedge clk) begin
        if (allocValid)
            info[tail] <= robAlloc;
        if (result.valid)
            value[result.robIdx] <= result.result;

        commit.rd <= info[head].rd;
        commit.value <= info[head].hasDst ? value[head] : '0; // Writes to r0 commit zero.
        freeTag <= info[head].tagOld;

        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            done <= '0;
            commit.valid <= 1'b0;
            freeValid <= 1'b0;
        end else begin
            // Allocation never targets an entry that is still in flight.
            if (allocValid) begin
                done[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (result.valid)
                done[result.robIdx] <= 1'b1;
            if (doCommit)
                head <= head + 1'b1;

            count <= count + allocValid - doCommit;
            commit.valid <= doCommit;
            freeValid <= doCommit && info[head].hasDst; // Old mapping goes back to rename.
        end
    end

endmodule

//--- hdl/RegFile.sv
module RegFile (
    input  logic              clk,
    input  logic              rst,
    input  CorePkg::PhysTag   readTagA,
    input  CorePkg::PhysTag   readTagB,
    output CorePkg::Word      readA,
    output CorePkg::Word      readB,
    input  CorePkg::ResultBus result
);
    import CorePkg::*;

    Word regs [NUM_PHYS_REGS];

    assign readA = regs[readTagA];
    assign readB = regs[readTagB];

    // Physical 0 only ever backs r0, so it keeps its zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (result.valid && result.hasDst) begin
            regs[result.tagDst] <= result.result;
        end
    end

endmodule

//--- hdl/Rename.sv
module Rename (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instrValid,
    input  CorePkg::DispatchInstr instr,
    input  logic                  iqFull,
    input  logic                  robFull,
    input  CorePkg::RobIdx        allocIdx,
    input  CorePkg::ResultBus     result,
    input  logic                  freeValid,
    input  CorePkg::PhysTag       freeTag,
    output logic                  stall,
    output logic                  enqValid,
    output CorePkg::RenamedUOp    uop,
    output CorePkg::RobAlloc      robAlloc
);
    import CorePkg::*;

    PhysTag mapTable [NUM_ARCH_REGS];
    logic [NUM_PHYS_REGS-1:0] freeMask;
    logic [NUM_PHYS_REGS-1:0] busy;
    PhysTag newTag;
    PhysTag tagA;
    PhysTag tagB;
    logic needDst;
    logic resWrites;

    assign needDst = instr.rd != '0;
    assign resWrites = result.valid && result.hasDst;
    assign tagA = mapTable[instr.rs1];
    assign tagB = mapTable[instr.rs2];

    // Stall when the free list is empty or either back-end structure is full.
    assign stall = robFull || iqFull || freeMask == '0;
    assign enqValid = instrValid && !stall;

    // Lowest free physical register.
    always_comb begin
        newTag = '0;
        for (int i = NUM_PHYS_REGS - 1; i >= 0; i--) begin
            if (freeMask[i])
                newTag = PhysTag'(i);
        end
    end

    always_comb begin
        uop.op = instr.op;
        uop.hasDst = needDst;
        uop.tagDst = newTag;
        uop.tagA = tagA;
        uop.readyA = instr.rs1 == '0 || !busy[tagA] || (resWrites && result.tagDst == tagA);
        uop.tagB = tagB;
        uop.readyB = instr.useImm || instr.rs2 == '0 || !busy[tagB] ||
                     (resWrites && result.tagDst == tagB);
        uop.useImm = instr.useImm;
        uop.imm = instr.imm;
        uop.robIdx = allocIdx;

        robAlloc.rd = instr.rd;
        robAlloc.hasDst = needDst;
        robAlloc.tagOld = mapTable[instr.rd];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                mapTable[r] <= PhysTag'(r); // Identity mapping.
            end
            for (int p = 0; p < NUM_PHYS_REGS; p++) begin
                freeMask[p] <= p >= NUM_ARCH_REGS;
            end
            busy <= '0;
        end else begin
            if (resWrites)
                busy[result.tagDst] <= 1'b0;
            if (freeValid)
                freeMask[freeTag] <= 1'b1;

            // A tag freed at this edge is not yet in the free mask and cannot be allocated.
            if (enqValid && needDst) begin
                mapTable[instr.rd] <= newTag;
                freeMask[newTag] <= 1'b0;
                busy[newTag] <= 1'b1;
            end
        end
    end

endmodule

//--- test/CoreTb.sv
module CoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    import CorePkg::*;

    localparam int CLK_PERIOD = 20;

    logic clk;
    logic rst;
    logic instrValid;
    DispatchInstr instr;
    logic stall;
    CommitInfo commit;

    DispatchInstr stim [$];
    Word expValue [$];
    int testNum [$];

    int numInstr = 0;
    int commitIdx = 0;
    int errors = 0;
    int testErrors = 0;
    int testChecks = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int stallCycles = 0;
    logic accepted;
    logic loaded = 1'b0;

    Core dut_i (
        .clk(clk),
        .rst(rst),
        .instrValid(instrValid),
        .instr(instr),
        .stall(stall),
        .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Translates the mnemonic in the data file and gives -1 for an unknown one.
    function automatic int opCode(string name);
        if (name == "ADD") return 0;
        if (name == "SUB") return 1;
        if (name == "AND") return 2;
        if (name == "OR") return 3;
        if (name == "XOR") return 4;
        if (name == "SLT") return 5;
        if (name == "SLL") return 6;
        if (name == "SRL") return 7;
        return -1;
    endfunction

    task automatic loadTests(output bit ok);
        int fd;
        int n;
        int code;
        int rd;
        int rs1;
        int rs2;
        int useImm;
        int tnum;
        string line;
        string opName;
        logic [31:0] imm;
        logic [31:0] expVal;
        DispatchInstr di;
        ok = 1'b1;
        fd = $fopen("test/core_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/core_testdata.txt");
            ok = 1'b0;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line[0] == "#")
                continue;
            n = $sscanf(line, "%s %d %d %d %d %h %h %d",
                        opName, rd, rs1, rs2, useImm, imm, expVal, tnum);
            if (n <= 0)
                continue; // Blank line.
            code = opCode(opName);
            if (n != 8 || code < 0) begin
                $display("Malformed line in test data: %s", line);
                ok = 1'b0;
                continue;
            end
            di.op = AluOp'(code);
            di.rd = ArchReg'(rd);
            di.rs1 = ArchReg'(rs1);
            di.rs2 = ArchReg'(rs2);
            di.useImm = useImm != 0;
            di.imm = imm[IMM_BITS-1:0];
            stim.push_back(di);
            expValue.push_back(expVal);
            testNum.push_back(tnum);
        end
        $fclose(fd);
        numInstr = stim.size();
    endtask

    task automatic finishTest(int num);
        if (testErrors == 0) begin
            $display("Test %0d passed (%0d checks)", num, testChecks);
            testsPassed++;
        end else begin
            $display("Test %0d failed (%0d of %0d checks wrong)", num, testErrors, testChecks);
            testsFailed++;
        end
        errors += testErrors;
        testErrors = 0;
        testChecks = 0;
    endtask

    task automatic checkCommit();
        DispatchInstr di;
        if (commitIdx >= numInstr) begin
            $display("Unexpected commit of r%0d after every instruction had retired", commit.rd);
            errors++;
            return;
        end
        di = stim[commitIdx];
        testChecks += 2;
        assert (commit.rd == di.rd) else begin
            $display("FAIL commit.rd got 0x%0h expected 0x%0h (test %0d, instr %0d)",
                     commit.rd, di.rd, testNum[commitIdx], commitIdx);
            testErrors++;
        end
        assert (commit.value == expValue[commitIdx]) else begin
            $display("FAIL commit.value got 0x%08h expected 0x%08h (test %0d, instr %0d)",
                     commit.value, expValue[commitIdx], testNum[commitIdx], commitIdx);
            testErrors++;
        end
        commitIdx++;
        if (commitIdx == numInstr || testNum[commitIdx] != testNum[commitIdx-1])
            finishTest(testNum[commitIdx-1]);
    endtask

    task automatic printSummary();
        $display("Tests passed %0d, failed %0d, commits %0d/%0d, errors %0d, stall cycles %0d",
                 testsPassed, testsFailed, commitIdx, numInstr, errors, stallCycles);
    endtask

    // Acceptance is sampled at the rising edge and read by the driver at the next falling edge.
    always @(posedge clk) begin
        accepted <= instrValid && !stall;
        if (instrValid && stall)
            stallCycles <= stallCycles + 1;
    end

    always @(negedge clk) begin
        if (!rst && commit.valid)
            checkCommit();
    end

    initial begin
        bit ok;
        rst = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        loadTests(ok);
        if (!ok) begin
            $display("Test data could not be loaded");
            $display("CHECKS FAILED");
            $finish;
        end
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        testChecks += 2;
        assert (!stall) else begin
            $display("FAIL stall got 0x%0h expected 0x0 after reset", stall);
            testErrors++;
        end
        assert (!commit.valid) else begin
            $display("FAIL commit.valid got 0x%0h expected 0x0 after reset", commit.valid);
            testErrors++;
        end
        rst = 1'b0;

        // Each instruction is held until a rising edge sees it accepted.
        foreach (stim[i]) begin
            instr = stim[i];
            instrValid = 1'b1;
            @(negedge clk);
            while (!accepted)
                @(negedge clk);
        end
        instrValid = 1'b0;

        wait (commitIdx == numInstr);
        repeat (ROB_SIZE + 4) @(negedge clk); // Room for any stray commit.
        assert (stallCycles > 0) else begin
            $display("Stall never held back an instruction during the run");
            errors++;
        end
        printSummary();
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        longint limit;
        wait (loaded === 1'b1);
        limit = longint'(numInstr * (ROB_SIZE + 8) + 3) * CLK_PERIOD;
        #(limit);
        $display("Timeout with only %0d of %0d instructions committed", commitIdx, numInstr);
        printSummary();
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- test/core_testdata.txt
# op rd rs1 rs2 useImm imm(hex, 12 bit) expected(hex) test
# The expected column is the value that the instruction commits to rd.
ADD 0 0 0 1 000 00000000 1
ADD 1 1 0 1 000 00000000 1
ADD 2 2 0 1 000 00000000 1
ADD 3 3 0 1 000 00000000 1
ADD 4 4 0 1 000 00000000 1
ADD 5 5 0 1 000 00000000 1
ADD 6 6 0 1 000 00000000 1
ADD 7 7 0 1 000 00000000 1
ADD 1 0 0 1 123 00000123 2
ADD 2 0 0 1 ffe fffffffe 2
SUB 3 1 2 0 000 00000125 2
SUB 4 2 0 1 005 fffffff9 2
AND 5 1 0 1 0f0 00000020 2
AND 6 2 1 0 000 00000122 2
OR  7 1 0 1 800 fffff923 2
OR  5 5 3 0 000 00000125 2
XOR 6 6 0 1 7ff 000006dd 2
XOR 3 3 2 0 000 fffffedb 2
SLT 4 2 1 0 000 00000001 2
SLT 6 1 0 1 124 00000001 2
SLT 7 2 0 1 fff 00000001 2
SLL 1 1 0 1 004 00001230 2
SRL 4 2 0 1 01c 0000000f 2
SRL 5 2 6 0 000 7fffffff 2
SLL 7 7 2 0 000 40000000 2
SRL 6 1 0 1 fe4 00000123 2
ADD 1 1 1 0 000 00002460 3
ADD 1 1 4 0 000 0000246f 3
SUB 2 1 6 0 000 0000234c 3
XOR 3 2 1 0 000 00000723 3
SLL 4 3 0 1 004 00007230 3
OR  5 4 2 0 000 0000737c 3
ADD 1 1 0 1 001 00002470 4
SUB 1 1 0 1 010 00002460 4
SLL 1 1 0 1 001 000048c0 4
SRL 1 1 0 1 002 00001230 4
XOR 2 6 0 1 0ff 000001dc 4
SUB 3 7 0 1 001 3fffffff 4
ADD 1 0 0 1 001 00000001 5
ADD 2 1 0 1 001 00000002 5
ADD 3 2 0 1 001 00000003 5
ADD 4 3 0 1 001 00000004 5
ADD 5 4 0 1 001 00000005 5
ADD 6 5 0 1 001 00000006 5
ADD 7 6 0 1 001 00000007 5
ADD 1 7 0 1 001 00000008 5
ADD 2 1 0 1 001 00000009 5
ADD 3 2 0 1 001 0000000a 5
ADD 4 3 0 1 001 0000000b 5
ADD 5 4 4 0 000 00000016 5
ADD 0 1 0 1 7ff 00000000 6
XOR 0 2 3 0 000 00000000 6
ADD 6 0 0 1 000 00000000 6
OR  7 0 5 0 000 00000016 6
SUB 1 0 2 0 000 fffffff7 6
